// File: source/fc_pkg.sv
package fc_pkg;

  //==============================
  // Geometry
  //==============================

  // Bytes per chunk on every read port
  localparam int LANES = 32;
  // Byte address into shared memory
  localparam int ADDR_WIDTH = 19;

  //==============================
  // Value types
  //==============================

  // One signed operand
  typedef logic signed [7:0] byte_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // Accumulator, also the written output word
  typedef logic signed [31:0] acc_t;
  // Lane 0 sits in the low byte
  typedef byte_t [LANES-1:0] chunk_t;

  //==============================
  // Memory port bundles
  //==============================

  // Level request, held until the response valid
  typedef struct packed {
    logic  req;
    addr_t addr;
  } rd_req_t;

  // Single-cycle valid with the chunk
  typedef struct packed {
    logic   valid;
    chunk_t data;
  } rd_rsp_t;

  // Held with address and data until ack
  typedef struct packed {
    logic  req;
    addr_t addr;
    acc_t  data;
  } wr_req_t;

  // Layer sequencer states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DRAIN,
    ACT,
    WRITE
  } fc_state_t;

endpackage

// File: source/fc_control.sv
`timescale 1ns/1ps

module fc_control #(
  parameter int ROW_BITS   = 7,
  parameter int CHUNK_BITS = 3
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fc_go,
  input  logic [CHUNK_BITS-1:0] fc_xm,
  input  logic [ROW_BITS-1:0]   fc_yn,
  input  fc_pkg::rd_rsp_t       rd_data_rsp,
  input  fc_pkg::rd_rsp_t       rd_wgt_rsp,
  input  fc_pkg::rd_rsp_t       rd_bias_rsp,
  input  logic                  wr_ack,
  input  logic                  row_ready,
  output logic                  fetch_start,
  output logic                  chunk_taken,
  output logic                  row_next,
  output logic                  run_start,
  output logic                  chunk_valid,
  output logic                  bias_valid,
  output fc_pkg::chunk_t        data_chunk,
  output fc_pkg::chunk_t        wgt_chunk,
  output logic                  rd_data_on,
  output logic                  rd_wgt_on,
  output logic                  rd_bias_on,
  output logic                  wr_on,
  output logic                  fc_busy,
  output logic                  fc_done
);

  fc_pkg::fc_state_t state_q;
  fc_pkg::fc_state_t state_d;

  // Run parameters captured on go
  logic [CHUNK_BITS-1:0] xm_q;
  logic [ROW_BITS-1:0]   yn_q;
  logic [CHUNK_BITS-1:0] chunk_cnt;
  logic [ROW_BITS-1:0]   row_cnt;

  // Responses already seen for the chunk in flight
  logic got_data;
  logic got_wgt;
  logic got_bias;
  logic data_hit;
  logic wgt_hit;
  logic bias_hit;
  logic last_chunk;
  logic last_row;

  // Early arrivals wait here for the slower port
  fc_pkg::chunk_t data_hold;
  fc_pkg::chunk_t wgt_hold;

  //==============================
  // Take logic
  //==============================

  // Response counts only while its request is up
  assign data_hit = rd_data_rsp.valid && rd_data_on;
  assign wgt_hit  = rd_wgt_rsp.valid && rd_wgt_on;
  assign bias_hit = rd_bias_rsp.valid && rd_bias_on;

  assign last_chunk = (chunk_cnt == CHUNK_BITS'(xm_q - 1'b1));
  assign last_row   = (row_cnt == ROW_BITS'(yn_q - 1'b1));

  // Bias is only fetched with a row's first chunk
  assign chunk_taken = (state_q == fc_pkg::FETCH) &&
                       (got_data || data_hit) &&
                       (got_wgt || wgt_hit) &&
                       ((chunk_cnt != '0) || got_bias || bias_hit);

  assign chunk_valid = chunk_taken;
  assign bias_valid  = bias_hit;
  assign run_start   = (state_q == fc_pkg::IDLE) && fc_go;
  assign row_next    = (state_q == fc_pkg::WRITE) && wr_ack;
  assign wr_on       = (state_q == fc_pkg::WRITE);

  // Live bus in its valid cycle or else the held copy
  assign data_chunk = data_hit ? rd_data_rsp.data : data_hold;
  assign wgt_chunk  = wgt_hit ? rd_wgt_rsp.data : wgt_hold;

  always_ff @(posedge clk)
  begin
    if (data_hit)
      data_hold <= rd_data_rsp.data;
    if (wgt_hit)
      wgt_hold <= rd_wgt_rsp.data;
  end

  //==============================
  // State machine
  //==============================

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      fc_pkg::IDLE:
        if (fc_go)
          state_d = fc_pkg::FETCH;
      fc_pkg::FETCH:
        if (chunk_taken && last_chunk)
          state_d = fc_pkg::DRAIN;
      // Pipeline still holds up to two chunks here
      fc_pkg::DRAIN:
        if (row_ready)
          state_d = fc_pkg::ACT;
      fc_pkg::ACT:
        state_d = fc_pkg::WRITE;
      fc_pkg::WRITE:
        if (wr_ack)
          state_d = last_row ? fc_pkg::IDLE : fc_pkg::FETCH;
      default:
        state_d = fc_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= fc_pkg::IDLE;
      xm_q        <= '0;
      yn_q        <= '0;
      chunk_cnt   <= '0;
      row_cnt     <= '0;
      fetch_start <= 1'b0;
      rd_data_on  <= 1'b0;
      rd_wgt_on   <= 1'b0;
      rd_bias_on  <= 1'b0;
      got_data    <= 1'b0;
      got_wgt     <= 1'b0;
      got_bias    <= 1'b0;
      fc_busy     <= 1'b0;
      fc_done     <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Next fetch one cycle after go, a take or a write ack
      fetch_start <= run_start || (chunk_taken && !last_chunk) ||
                     (row_next && !last_row);
      if (run_start)
      begin
        xm_q <= fc_xm;
        yn_q <= fc_yn;
      end

      // Request levels rise on fetch and fall after their response
      if (fetch_start)
        rd_data_on <= 1'b1;
      else if (data_hit)
        rd_data_on <= 1'b0;
      if (fetch_start)
        rd_wgt_on <= 1'b1;
      else if (wgt_hit)
        rd_wgt_on <= 1'b0;
      if (fetch_start && (chunk_cnt == '0))
        rd_bias_on <= 1'b1;
      else if (bias_hit)
        rd_bias_on <= 1'b0;

      // Arrival flags clear when the chunk moves on
      got_data <= !chunk_taken && (got_data || data_hit);
      got_wgt  <= !chunk_taken && (got_wgt || wgt_hit);
      got_bias <= !chunk_taken && (got_bias || bias_hit);

      if (run_start)
        chunk_cnt <= '0;
      else if (chunk_taken)
        chunk_cnt <= last_chunk ? '0 : chunk_cnt + 1'b1;
      if (run_start)
        row_cnt <= '0;
      else if (row_next && !last_row)
        row_cnt <= row_cnt + 1'b1;

      // Busy drops on the same edge that done rises
      if (run_start)
        fc_busy <= 1'b1;
      else if (row_next && last_row)
        fc_busy <= 1'b0;
      fc_done <= row_next && last_row;
    end
  end

  //==============================
  // Checks
  //==============================

  // A response must land on a request that is still up
  a_data_held: assert property (@(posedge clk) disable iff (!rst_n)
    rd_data_rsp.valid |-> rd_data_on);
  a_wgt_held: assert property (@(posedge clk) disable iff (!rst_n)
    rd_wgt_rsp.valid |-> rd_wgt_on);
  a_bias_held: assert property (@(posedge clk) disable iff (!rst_n)
    rd_bias_rsp.valid |-> rd_bias_on);
  a_wr_held: assert property (@(posedge clk) disable iff (!rst_n)
    wr_ack |-> wr_on);

endmodule

// File: source/fc_addr_gen.sv
`timescale 1ns/1ps

module fc_addr_gen (
  input  logic            clk,
  input  logic            rst_n,
  input  fc_pkg::addr_t   fc_addrx,
  input  fc_pkg::addr_t   fc_addry,
  input  fc_pkg::addr_t   fc_addrb,
  input  fc_pkg::addr_t   fc_addrz,
  input  logic            fetch_start,
  input  logic            chunk_taken,
  input  logic            row_next,
  input  logic            run_start,
  input  logic            rd_data_on,
  input  logic            rd_wgt_on,
  input  logic            rd_bias_on,
  input  logic            wr_on,
  input  fc_pkg::acc_t    row_result,
  output fc_pkg::rd_req_t rd_data_req,
  output fc_pkg::rd_req_t rd_wgt_req,
  output fc_pkg::rd_req_t rd_bias_req,
  output fc_pkg::wr_req_t wr_req
);

  // Running pointers
  fc_pkg::addr_t data_ptr;
  fc_pkg::addr_t wgt_ptr;
  fc_pkg::addr_t bias_ptr;
  fc_pkg::addr_t out_ptr;
  // Snapshot per fetch keeps a held request's address
  fc_pkg::addr_t data_addr_q;
  fc_pkg::addr_t wgt_addr_q;
  fc_pkg::addr_t bias_addr_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_ptr <= '0;
      wgt_ptr  <= '0;
      bias_ptr <= '0;
      out_ptr  <= '0;
    end
    else if (run_start)
    begin
      data_ptr <= fc_addrx;
      wgt_ptr  <= fc_addry;
      bias_ptr <= fc_addrb;
      out_ptr  <= fc_addrz;
    end
    else if (row_next)
    begin
      // Vector restarts while the matrix keeps running
      data_ptr <= fc_addrx;
      bias_ptr <= bias_ptr + fc_pkg::addr_t'(1);
      out_ptr  <= out_ptr + fc_pkg::addr_t'(4);
    end
    else if (chunk_taken)
    begin
      data_ptr <= data_ptr + fc_pkg::addr_t'(fc_pkg::LANES);
      wgt_ptr  <= wgt_ptr + fc_pkg::addr_t'(fc_pkg::LANES);
    end
  end

  always_ff @(posedge clk)
  begin
    if (fetch_start)
    begin
      data_addr_q <= data_ptr;
      wgt_addr_q  <= wgt_ptr;
      bias_addr_q <= bias_ptr;
    end
  end

  assign rd_data_req.req  = rd_data_on;
  assign rd_data_req.addr = data_addr_q;
  assign rd_wgt_req.req   = rd_wgt_on;
  assign rd_wgt_req.addr  = wgt_addr_q;
  assign rd_bias_req.req  = rd_bias_on;
  assign rd_bias_req.addr = bias_addr_q;
  // Result stays put until row_next like the request
  assign wr_req.req  = wr_on;
  assign wr_req.addr = out_ptr;
  assign wr_req.data = row_result;

  // Address must not move under a held request
  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rd_data_req.req && $past(rd_data_req.req) |-> $stable(rd_data_req.addr));
  a_wgt_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rd_wgt_req.req && $past(rd_wgt_req.req) |-> $stable(rd_wgt_req.addr));
  a_bias_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rd_bias_req.req && $past(rd_bias_req.req) |-> $stable(rd_bias_req.addr));
  a_wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req.req && $past(wr_req.req) |-> $stable(wr_req.addr) && $stable(wr_req.data));

endmodule

// File: source/chunk_dot_product.sv
`timescale 1ns/1ps

module chunk_dot_product (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           chunk_valid,
  input  fc_pkg::chunk_t data_chunk,
  input  fc_pkg::chunk_t wgt_chunk,
  output logic           dp_valid,
  output fc_pkg::acc_t   dp_sum
);

  // Stage one, one product per lane
  logic signed [15:0] prod_q [fc_pkg::LANES];
  logic               prod_valid;
  fc_pkg::acc_t       sum_c;

  //==============================
  // Stage one
  //==============================

  // Operands only enter on a taken chunk
  always_ff @(posedge clk)
  begin
    if (chunk_valid)
    begin
      for (int i = 0; i < fc_pkg::LANES; i++)
        prod_q[i] <= data_chunk[i] * wgt_chunk[i];
    end
  end

  //==============================
  // Stage two
  //==============================

  // Adder tree, sign extended lanes
  always_comb
  begin
    sum_c = '0;
    for (int i = 0; i < fc_pkg::LANES; i++)
      sum_c = sum_c + fc_pkg::acc_t'(prod_q[i]);
  end

  always_ff @(posedge clk)
  begin
    if (prod_valid)
      dp_sum <= sum_c;
  end

  // Valid walks alongside the data
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prod_valid <= 1'b0;
      dp_valid   <= 1'b0;
    end
    else
    begin
      prod_valid <= chunk_valid;
      dp_valid   <= prod_valid;
    end
  end

endmodule

// File: source/row_accumulator.sv
`timescale 1ns/1ps

module row_accumulator #(
  parameter int CHUNK_BITS = 3
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  dp_valid,
  input  fc_pkg::acc_t          dp_sum,
  input  logic                  bias_valid,
  input  fc_pkg::byte_t         bias,
  input  logic [CHUNK_BITS-1:0] fc_xm,
  input  logic                  row_next,
  output logic                  row_ready,
  output fc_pkg::acc_t          row_result
);

  fc_pkg::byte_t         bias_q;
  fc_pkg::acc_t          acc_q;
  logic [CHUNK_BITS-1:0] cnt_q;
  logic                  last_c;
  fc_pkg::acc_t          total_c;

  // Bias arrives once per row, ahead of the first chunk
  always_ff @(posedge clk)
  begin
    if (bias_valid)
      bias_q <= bias;
  end

  assign last_c  = (cnt_q == CHUNK_BITS'(fc_xm - 1'b1));
  // Full row value, bias sign extended
  assign total_c = acc_q + dp_sum + fc_pkg::acc_t'(bias_q);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_q      <= '0;
      cnt_q      <= '0;
      row_ready  <= 1'b0;
      row_result <= '0;
    end
    else if (row_next)
    begin
      acc_q     <= '0;
      cnt_q     <= '0;
      row_ready <= 1'b0;
    end
    else if (dp_valid)
    begin
      if (last_c)
      begin
        row_ready  <= 1'b1;
        // Step activation, zero or below is written as zero
        row_result <= (total_c > 0) ? total_c : '0;
      end
      else
      begin
        acc_q <= acc_q + dp_sum;
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Next row's chunks only after the write is acked
  a_no_late_chunk: assert property (@(posedge clk) disable iff (!rst_n)
    row_ready && !row_next |-> !dp_valid);

endmodule

// File: source/fc_layer_top.sv
`timescale 1ns/1ps

module fc_layer_top #(
  parameter int ROW_BITS   = 7,
  parameter int CHUNK_BITS = 3
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fc_go,
  input  fc_pkg::addr_t         fc_addrx,
  input  fc_pkg::addr_t         fc_addry,
  input  fc_pkg::addr_t         fc_addrb,
  input  fc_pkg::addr_t         fc_addrz,
  input  logic [CHUNK_BITS-1:0] fc_xm,
  input  logic [ROW_BITS-1:0]   fc_yn,
  input  fc_pkg::rd_rsp_t       rd_data_rsp,
  input  fc_pkg::rd_rsp_t       rd_wgt_rsp,
  input  fc_pkg::rd_rsp_t       rd_bias_rsp,
  input  logic                  wr_ack,
  output fc_pkg::rd_req_t       rd_data_req,
  output fc_pkg::rd_req_t       rd_wgt_req,
  output fc_pkg::rd_req_t       rd_bias_req,
  output fc_pkg::wr_req_t       wr_req,
  output logic                  fc_busy,
  output logic                  fc_done
);

  // Sequencer strobes
  logic fetch_start;
  logic chunk_taken;
  logic row_next;
  logic run_start;
  // Request enables
  logic rd_data_on;
  logic rd_wgt_on;
  logic rd_bias_on;
  logic wr_on;
  // Datapath
  logic           chunk_valid;
  logic           bias_valid;
  fc_pkg::chunk_t data_chunk;
  fc_pkg::chunk_t wgt_chunk;
  logic           dp_valid;
  fc_pkg::acc_t   dp_sum;
  logic           row_ready;
  fc_pkg::acc_t   row_result;

  fc_control #(
    .ROW_BITS   (ROW_BITS),
    .CHUNK_BITS (CHUNK_BITS)
  ) u_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .fc_go       (fc_go),
    .fc_xm       (fc_xm),
    .fc_yn       (fc_yn),
    .rd_data_rsp (rd_data_rsp),
    .rd_wgt_rsp  (rd_wgt_rsp),
    .rd_bias_rsp (rd_bias_rsp),
    .wr_ack      (wr_ack),
    .row_ready   (row_ready),
    .fetch_start (fetch_start),
    .chunk_taken (chunk_taken),
    .row_next    (row_next),
    .run_start   (run_start),
    .chunk_valid (chunk_valid),
    .bias_valid  (bias_valid),
    .data_chunk  (data_chunk),
    .wgt_chunk   (wgt_chunk),
    .rd_data_on  (rd_data_on),
    .rd_wgt_on   (rd_wgt_on),
    .rd_bias_on  (rd_bias_on),
    .wr_on       (wr_on),
    .fc_busy     (fc_busy),
    .fc_done     (fc_done)
  );

  fc_addr_gen u_addr_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .fc_addrx    (fc_addrx),
    .fc_addry    (fc_addry),
    .fc_addrb    (fc_addrb),
    .fc_addrz    (fc_addrz),
    .fetch_start (fetch_start),
    .chunk_taken (chunk_taken),
    .row_next    (row_next),
    .run_start   (run_start),
    .rd_data_on  (rd_data_on),
    .rd_wgt_on   (rd_wgt_on),
    .rd_bias_on  (rd_bias_on),
    .wr_on       (wr_on),
    .row_result  (row_result),
    .rd_data_req (rd_data_req),
    .rd_wgt_req  (rd_wgt_req),
    .rd_bias_req (rd_bias_req),
    .wr_req      (wr_req)
  );

  chunk_dot_product u_dot (
    .clk         (clk),
    .rst_n       (rst_n),
    .chunk_valid (chunk_valid),
    .data_chunk  (data_chunk),
    .wgt_chunk   (wgt_chunk),
    .dp_valid    (dp_valid),
    .dp_sum      (dp_sum)
  );

  // Only lane 0 of the bias chunk is used
  row_accumulator #(
    .CHUNK_BITS (CHUNK_BITS)
  ) u_row_acc (
    .clk        (clk),
    .rst_n      (rst_n),
    .dp_valid   (dp_valid),
    .dp_sum     (dp_sum),
    .bias_valid (bias_valid),
    .bias       (rd_bias_rsp.data[0]),
    .fc_xm      (fc_xm),
    .row_next   (row_next),
    .row_ready  (row_ready),
    .row_result (row_result)
  );

endmodule

// File: tb/fc_mem_model.sv
`timescale 1ns/1ps

module fc_mem_model (
  input  logic            clk,
  input  fc_pkg::rd_req_t rd_data_req,
  input  fc_pkg::rd_req_t rd_wgt_req,
  input  fc_pkg::rd_req_t rd_bias_req,
  input  fc_pkg::wr_req_t wr_req,
  output fc_pkg::rd_rsp_t rd_data_rsp,
  output fc_pkg::rd_rsp_t rd_wgt_rsp,
  output fc_pkg::rd_rsp_t rd_bias_rsp,
  output logic            wr_ack,
  output logic            wr_seen,
  output fc_pkg::addr_t   wr_seen_addr,
  output fc_pkg::acc_t    wr_seen_data,
  output int              wr_count,
  output int              proto_errors
);

  // Sparse byte store, filled by the testbench
  logic [7:0] store [fc_pkg::addr_t];

  // Port slots 0 data, 1 weight, 2 bias, 3 write
  int            lat [0:3];
  logic          drop_wait [0:3];
  logic          hit [0:3];
  fc_pkg::addr_t held_addr [0:3];
  string         port_name [0:3];

  task automatic load_byte(input fc_pkg::addr_t a, input logic [7:0] v);
    store[a] = v;
  endtask

  // Unloaded bytes, a mix of every address bit
  function automatic logic [7:0] byte_at(input fc_pkg::addr_t a);
    if (store.exists(a))
      return store[a];
    else
      return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]};
  endfunction

  // Lane i from base plus i
  function automatic fc_pkg::chunk_t read_chunk(input fc_pkg::addr_t base);
    fc_pkg::chunk_t c;
    fc_pkg::addr_t  a;
    c = '0;
    for (int i = 0; i < fc_pkg::LANES; i++)
    begin
      a = fc_pkg::addr_t'(base + i);
      c = c | (fc_pkg::chunk_t'(byte_at(a)) << (8 * i));
    end
    return c;
  endfunction

  //==============================
  // Per port handshake
  //==============================

  task automatic step_port(input logic [1:0] p, input logic req, input fc_pkg::addr_t addr);
    hit[p] = 1'b0;
    if (drop_wait[p])
    begin
      // Request falls right after its response
      if (req)
      begin
        $display("Error: %s request still high the cycle after its response", port_name[p]);
        proto_errors++;
      end
      drop_wait[p] = 1'b0;
    end
    else if (req)
    begin
      // New request, pick a latency
      if (lat[p] == 0)
      begin
        lat[p]       = int'($urandom_range(4, 1));
        held_addr[p] = addr;
      end
      else if (addr != held_addr[p])
      begin
        $display("Error: %s address moved from %h to %h while held",
                 port_name[p], held_addr[p], addr);
        proto_errors++;
      end
      lat[p]--;
      if (lat[p] == 0)
      begin
        hit[p]       = 1'b1;
        drop_wait[p] = 1'b1;
      end
    end
    else if (lat[p] != 0)
    begin
      $display("Error: %s request dropped before its response", port_name[p]);
      proto_errors++;
      lat[p] = 0;
    end
  endtask

  initial
  begin
    rd_data_rsp  = '0;
    rd_wgt_rsp   = '0;
    rd_bias_rsp  = '0;
    wr_ack       = 1'b0;
    wr_seen      = 1'b0;
    wr_seen_addr = '0;
    wr_seen_data = '0;
    wr_count     = 0;
    proto_errors = 0;
    lat          = '{default: 0};
    drop_wait    = '{default: 1'b0};
    hit          = '{default: 1'b0};
    held_addr    = '{default: '0};
    port_name    = '{"data", "weight", "bias", "write"};
    forever
    begin
      @(posedge clk);
      // Requests are registered, settled by now
      #1;
      step_port(2'd0, rd_data_req.req, rd_data_req.addr);
      step_port(2'd1, rd_wgt_req.req, rd_wgt_req.addr);
      step_port(2'd2, rd_bias_req.req, rd_bias_req.addr);
      step_port(2'd3, wr_req.req, wr_req.addr);
      rd_data_rsp.valid = hit[0];
      rd_data_rsp.data  = hit[0] ? read_chunk(held_addr[0]) : '0;
      rd_wgt_rsp.valid  = hit[1];
      rd_wgt_rsp.data   = hit[1] ? read_chunk(held_addr[1]) : '0;
      rd_bias_rsp.valid = hit[2];
      rd_bias_rsp.data  = hit[2] ? read_chunk(held_addr[2]) : '0;
      wr_ack  = hit[3];
      wr_seen = hit[3];
      // Log the acked write
      if (hit[3])
      begin
        wr_seen_addr = wr_req.addr;
        wr_seen_data = wr_req.data;
        wr_count++;
      end
    end
  end

endmodule

// File: tb/fc_layer_tb.sv
`timescale 1ns/1ps

module fc_layer_tb;

  localparam int ROW_BITS   = 7;
  localparam int CHUNK_BITS = 3;
  localparam int SEED       = 93859;
  // Runs of 1x1, 4x3 and 3x2 chunks
  localparam int TOTAL_CHUNKS = 1 + 12 + 6;
  localparam int MAX_CYCLES   = 20 * TOTAL_CHUNKS + 2000;

  logic                  clk;
  logic                  rst_n;
  logic                  fc_go;
  fc_pkg::addr_t         fc_addrx;
  fc_pkg::addr_t         fc_addry;
  fc_pkg::addr_t         fc_addrb;
  fc_pkg::addr_t         fc_addrz;
  logic [CHUNK_BITS-1:0] fc_xm;
  logic [ROW_BITS-1:0]   fc_yn;
  fc_pkg::rd_rsp_t       rd_data_rsp;
  fc_pkg::rd_rsp_t       rd_wgt_rsp;
  fc_pkg::rd_rsp_t       rd_bias_rsp;
  logic                  wr_ack;
  fc_pkg::rd_req_t       rd_data_req;
  fc_pkg::rd_req_t       rd_wgt_req;
  fc_pkg::rd_req_t       rd_bias_req;
  fc_pkg::wr_req_t       wr_req;
  logic                  fc_busy;
  logic                  fc_done;

  // Write log from the memory model
  logic          wr_seen;
  fc_pkg::addr_t wr_seen_addr;
  fc_pkg::acc_t  wr_seen_data;
  int            wr_count;
  int            proto_errors;

  // Operand copies for the reference
  fc_pkg::byte_t vec_b [];
  fc_pkg::byte_t wgt_b [];
  fc_pkg::byte_t bias_b [];
  // Expected writes in order with cmp_idx walking them
  fc_pkg::addr_t exp_addr_q [$];
  fc_pkg::acc_t  exp_data_q [$];
  int            cmp_idx = 0;
  int            cmp_errors = 0;
  int            done_pulses = 0;

  string      test_name;
  int         errors;
  int         err_start;
  int         tests_passed;
  int         tests_failed;
  int         cycles;
  logic [5:0] idle_bits;

  fc_layer_top #(
    .ROW_BITS   (ROW_BITS),
    .CHUNK_BITS (CHUNK_BITS)
  ) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .fc_go       (fc_go),
    .fc_addrx    (fc_addrx),
    .fc_addry    (fc_addry),
    .fc_addrb    (fc_addrb),
    .fc_addrz    (fc_addrz),
    .fc_xm       (fc_xm),
    .fc_yn       (fc_yn),
    .rd_data_rsp (rd_data_rsp),
    .rd_wgt_rsp  (rd_wgt_rsp),
    .rd_bias_rsp (rd_bias_rsp),
    .wr_ack      (wr_ack),
    .rd_data_req (rd_data_req),
    .rd_wgt_req  (rd_wgt_req),
    .rd_bias_req (rd_bias_req),
    .wr_req      (wr_req),
    .fc_busy     (fc_busy),
    .fc_done     (fc_done)
  );

  fc_mem_model u_mem (
    .clk          (clk),
    .rd_data_req  (rd_data_req),
    .rd_wgt_req   (rd_wgt_req),
    .rd_bias_req  (rd_bias_req),
    .wr_req       (wr_req),
    .rd_data_rsp  (rd_data_rsp),
    .rd_wgt_rsp   (rd_wgt_rsp),
    .rd_bias_rsp  (rd_bias_rsp),
    .wr_ack       (wr_ack),
    .wr_seen      (wr_seen),
    .wr_seen_addr (wr_seen_addr),
    .wr_seen_data (wr_seen_data),
    .wr_count     (wr_count),
    .proto_errors (proto_errors)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit
  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout, run still going after %0d cycles", cycles);
    $display("Test FAILED");
    $finish;
  end

  always @(posedge clk)
  begin
    if (fc_done === 1'b1)
      done_pulses++;
  end

  //==============================
  // Reference and compare
  //==============================

  // Bias plus dot product and then the step
  function automatic fc_pkg::acc_t expected_neuron(input int row, input int xm);
    int sum;
    int n;
    n   = xm * fc_pkg::LANES;
    sum = int'(bias_b[row]);
    for (int i = 0; i < n; i++)
      sum += int'(vec_b[i]) * int'(wgt_b[row * n + i]);
    if (sum > 0)
      return sum;
    else
      return 0;
  endfunction

  always @(posedge clk)
  begin
    if (wr_seen === 1'b1)
    begin
      if (cmp_idx >= exp_addr_q.size())
      begin
        $display("Error in %s: write to %h that no test expected", test_name, wr_seen_addr);
        cmp_errors++;
      end
      else
      begin
        if (wr_seen_addr !== exp_addr_q[cmp_idx])
        begin
          $display("FAIL %s address expected %h actual %h",
                   test_name, exp_addr_q[cmp_idx], wr_seen_addr);
          cmp_errors++;
        end
        if (wr_seen_data !== exp_data_q[cmp_idx])
        begin
          $display("FAIL %s word at %h expected %0d actual %0d",
                   test_name, wr_seen_addr, exp_data_q[cmp_idx], wr_seen_data);
          cmp_errors++;
        end
      end
      cmp_idx++;
    end
  end

  function automatic int total_errors();
    return errors + cmp_errors;
  endfunction

  task automatic report_result(input int err_before);
    int n;
    n = total_errors() - err_before;
    if (n == 0)
    begin
      $display("%s: ok", test_name);
      tests_passed++;
    end
    else
    begin
      $display("%s: %0d errors", test_name, n);
      tests_failed++;
    end
  endtask

  //==============================
  // Stimulus
  //==============================

  // Mode 0 known, 1 random, 2 sums at or below zero
  task automatic load_layer(input int mode, input int xm, input int yn, input fc_pkg::addr_t ax,
                            input fc_pkg::addr_t ay, input fc_pkg::addr_t ab);
    int n;
    int w;
    int b;
    n = xm * fc_pkg::LANES;
    for (int i = 0; i < n; i++)
    begin
      case (mode)
        0:       vec_b[i] = fc_pkg::byte_t'(i + 1);
        1:       vec_b[i] = fc_pkg::byte_t'($urandom);
        default: vec_b[i] = fc_pkg::byte_t'(1 + i % 16);
      endcase
      u_mem.load_byte(fc_pkg::addr_t'(ax + i), vec_b[i]);
    end
    for (int r = 0; r < yn; r++)
    begin
      // Rows sit back to back
      for (int i = 0; i < n; i++)
      begin
        case (mode)
          0:       w = (i % 2 == 0) ? 2 : -1;
          1:       w = $urandom;
          default: w = (r == 1) ? -(1 + i % 3) : 0;
        endcase
        wgt_b[r * n + i] = fc_pkg::byte_t'(w);
        u_mem.load_byte(fc_pkg::addr_t'(ay + r * n + i), wgt_b[r * n + i]);
      end
      case (mode)
        0:       b = 5;
        1:       b = $urandom;
        default: b = (r == 0) ? 0 : ((r == 1) ? 10 : -7);
      endcase
      bias_b[r] = fc_pkg::byte_t'(b);
      u_mem.load_byte(fc_pkg::addr_t'(ab + r), bias_b[r]);
    end
  endtask

  task automatic run_layer(input string name, input int xm, input int yn,
                           input fc_pkg::addr_t ax, input fc_pkg::addr_t ay,
                           input fc_pkg::addr_t ab, input fc_pkg::addr_t az);
    int wr_start;
    int done_start;
    test_name  = name;
    err_start  = total_errors();
    wr_start   = wr_count;
    done_start = done_pulses;
    for (int r = 0; r < yn; r++)
    begin
      exp_addr_q.push_back(fc_pkg::addr_t'(az + 4 * r));
      exp_data_q.push_back(expected_neuron(r, xm));
    end
    @(posedge clk);
    #1;
    fc_addrx = ax;
    fc_addry = ay;
    fc_addrb = ab;
    fc_addrz = az;
    fc_xm    = CHUNK_BITS'(xm);
    fc_yn    = ROW_BITS'(yn);
    fc_go    = 1'b1;
    @(posedge clk);
    #1;
    fc_go = 1'b0;
    // Busy from the edge after go up to done
    while (fc_done !== 1'b1)
    begin
      if (fc_busy !== 1'b1)
      begin
        $display("FAIL %s fc_busy expected 1 actual %b", name, fc_busy);
        errors++;
      end
      @(posedge clk);
      #1;
    end
    if (fc_busy !== 1'b0)
    begin
      $display("FAIL %s fc_busy with done expected 0 actual %b", name, fc_busy);
      errors++;
    end
    if (wr_count - wr_start != yn)
    begin
      $display("FAIL %s write count expected %0d actual %0d", name, yn, wr_count - wr_start);
      errors++;
    end
    @(posedge clk);
    #1;
    if (fc_done !== 1'b0)
    begin
      $display("FAIL %s fc_done second cycle expected 0 actual %b", name, fc_done);
      errors++;
    end
    repeat (3) @(posedge clk);
    #1;
    if (done_pulses - done_start != 1)
    begin
      $display("FAIL %s done pulses expected 1 actual %0d", name, done_pulses - done_start);
      errors++;
    end
    if (cmp_idx != exp_addr_q.size())
    begin
      $display("FAIL %s writes checked expected %0d actual %0d",
               name, exp_addr_q.size(), cmp_idx);
      errors++;
    end
    report_result(err_start);
  endtask

  initial
  begin
    rst_n        = 1'b0;
    fc_go        = 1'b0;
    fc_addrx     = '0;
    fc_addry     = '0;
    fc_addrb     = '0;
    fc_addrz     = '0;
    fc_xm        = '0;
    fc_yn        = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_name    = "reset";
    void'($urandom(SEED));
    vec_b  = new[256];
    wgt_b  = new[1024];
    bias_b = new[16];
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Quiet after reset
    test_name = "idle_after_reset";
    err_start = total_errors();
    repeat (10)
    begin
      @(posedge clk);
      #1;
      idle_bits = {rd_data_req.req, rd_wgt_req.req, rd_bias_req.req,
                   wr_req.req, fc_busy, fc_done};
      if (idle_bits !== 6'b0)
      begin
        $display("FAIL %s expected %b actual %b", test_name, 6'b0, idle_bits);
        errors++;
      end
    end
    report_result(err_start);

    load_layer(0, 1, 1, 19'h01000, 19'h02000, 19'h03000);
    run_layer("single_row_known", 1, 1, 19'h01000, 19'h02000, 19'h03000, 19'h04000);
    load_layer(1, 3, 4, 19'h10000, 19'h11000, 19'h12000);
    run_layer("random_4x3", 3, 4, 19'h10000, 19'h11000, 19'h12000, 19'h13000);
    load_layer(2, 2, 3, 19'h20000, 19'h21000, 19'h22000);
    run_layer("step_to_zero", 2, 3, 19'h20000, 19'h21000, 19'h22000, 19'h23000);

    // Held levels and stable addresses as seen by the model
    test_name = "request_protocol";
    err_start = total_errors();
    if (proto_errors != 0)
    begin
      $display("Memory ports saw %0d request protocol violations", proto_errors);
      errors++;
    end
    report_result(err_start);

    $display("Summary: %0d tests passed, %0d failed, %0d errors",
             tests_passed, tests_failed, total_errors());
    if (total_errors() == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: vlog.f
source/fc_pkg.sv
source/fc_control.sv
source/fc_addr_gen.sv
source/chunk_dot_product.sv
source/row_accumulator.sv
source/fc_layer_top.sv
tb/fc_mem_model.sv
tb/fc_layer_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fc_layer_tb
FILELIST  = vlog.f

OBJ_DIR = obj_dir
SIM_BIN = $(OBJ_DIR)/V$(TOP)
SIM_LOG = sim.log
SOURCES = $(shell cat $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@grep -q "^Test OK$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
